//--- Makefile
TOP := riscv64_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f riscv64_core.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- dv/riscv64_core_stimulus.hex
// @000 program words, @080 data preload at 0x1000, @0c0 irq cycle, end marker address,
// program word count, record count, @0c4 expected stores as address size data
@000
000010B7 FFB00113 00C00193 00310233 403102B3 0440B023
0450B423 00012313 003133B3 00431413 003144B3 00646533
003175B3 40615633 03C15693 0490B823 04A0BC23 06B0B023
06C0B423 06D0B823 06708C23 80000737 FFF7079B 0067883B
402188BB 0067993B 4047599B 0900B023 0910B423 0920B823
0930BC23 00000A17 0B40B023 00008A83 0020DB03 0040AB83
0040EC03 0080BC83 0010CD03 00009D83 0B50B423 0B609823
0B70AC23 0D80B023 0D90B423 0DA0B823 0DB0BC23 00211463
001E8E93 00314463 0E00BC23 0021F463 002E8E93 00630463
0E00BC23 0021E463 0E00BC23 0021D463 0E00BC23 00800E6F
0E00BC23 00000F17 00CF02E7 0E00BC23 0FD0B023 0FC0B423
0E50B823 34019073 34011473 340014F3 00000517 02850513
305515F3 30551673 1080B023 1090B423 10C0B823 000F8063
2000B023 0000006F 34201A73 1140BC23 00100F93 30200073
@080
F0E1D2C3B4A59687 0123456789ABCDEF
@0c0
190 1200 54 1B
// alu and immediate forms
1040 3 0000000000000007
1048 3 FFFFFFFFFFFFFFEF
1050 3 FFFFFFFFFFFFFFF7
1058 3 0000000000000011
1060 3 0000000000000008
1068 3 FFFFFFFFFFFFFFFD
1070 3 000000000000000F
1078 0 0000000000000000
// word forms and auipc
1080 3 FFFFFFFF80000000
1088 3 0000000000000011
1090 3 FFFFFFFFFFFFFFFE
1098 3 FFFFFFFFF8000000
10A0 3 000000008000007C
// loads stored back
10A8 3 FFFFFFFFFFFFFF87
10B0 1 000000000000B4A5
10B8 2 00000000F0E1D2C3
10C0 3 00000000F0E1D2C3
10C8 3 0123456789ABCDEF
10D0 3 0000000000000096
10D8 3 FFFFFFFFFFFF9687
// branch score and link values
10E0 3 0000000000000003
10E8 3 00000000800000F0
10F0 3 00000000800000FC
// csr old values, then mcause from the handler
1100 3 000000000000000C
1108 3 FFFFFFFFFFFFFFFB
1110 3 0000000080000140
1118 3 800000000000000B

//--- dv/riscv64_core_tb.sv
`include "riscv64_core_settings.svh"

module riscv64_core_tb import riscv64_core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIM_DEPTH = 512;
    localparam int DATA_IDX   = 'h080;  // data preload of 64 doublewords
    localparam int INFO_IDX   = 'h0c0;  // irq cycle, end marker, word count, record count
    localparam int REC_IDX    = 'h0c4;  // address, size, data per record
    localparam logic [63:0] DATA_BASE = 64'h1000;

    logic                   clk;
    logic                   reset;
    logic [31:0]            instruction;
    pc_t                    pc;
    logic                   irq;
    logic                   interrupt_ack;
    logic [`BUS_ADDR_W-1:0] bus_address;
    xlen_t                  bus_write_data;
    logic                   bus_write_enable;
    logic                   bus_read_enable;
    logic [2:0]             bus_ls_type;
    logic                   bus_read_done;
    logic                   bus_write_done;
    xlen_t                  bus_read_data;

    logic [63:0] stim [STIM_DEPTH];
    logic [63:0] dmem [64];        // 0x1000 to 0x11ff
    logic [63:0] end_addr;
    logic        end_seen = 1'b0;  // end marker store went out
    int          seed;
    int          cycle = 0;
    int          ack_count = 0;
    int          rec_next = 0;
    int          rec_count;
    int          prog_words;
    int          irq_cycle;
    int          timeout_cycles = 1000;
    pc_t         word_idx;

    riscv64_core u_dut (
        .clk (clk), .reset (reset), .instruction_i (instruction), .pc_o (pc),
        .irq_i (irq), .interrupt_ack_o (interrupt_ack), .bus_address_o (bus_address),
        .bus_write_data_o (bus_write_data), .bus_write_enable_o (bus_write_enable),
        .bus_read_enable_o (bus_read_enable), .bus_ls_type_o (bus_ls_type),
        .bus_read_done_i (bus_read_done), .bus_write_done_i (bus_write_done),
        .bus_read_data_i (bus_read_data)
    );

    always #20 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                 $time, name, expected, actual));
    endtask

    // final checks once the end marker store shows up
    task automatic finish_run();
        assert (ack_count == 1) else
            report_failure($sformatf("saw %0d interrupt acks instead of one", ack_count));
        if (rec_next == rec_count) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure($sformatf("only %0d of %0d store records seen", rec_next, rec_count));
        end
    endtask

    task automatic check_store(logic [63:0] addr, logic [2:0] size, logic [63:0] data);
        logic [63:0] mask;
        int          base;
        mask = (size[1:0] == 2'd3) ? '1 : (64'd1 << (8 << size[1:0])) - 64'd1;
        base = REC_IDX + 3 * rec_next;
        if (addr == end_addr) begin
            end_seen = 1'b1;  // program is done
        end else begin
            assert (rec_next < rec_count) else
                report_failure($sformatf("store to %h after the last expected record", addr));
            assert (addr == stim[base]) else report_mismatch("bus_address_o", stim[base], addr);
            assert (64'(size) == stim[base+1]) else
                report_mismatch("bus_ls_type_o", stim[base+1], 64'(size));
            assert ((data & mask) == stim[base+2]) else
                report_mismatch("bus_write_data_o", stim[base+2], data & mask);
            rec_next++;
        end
    endtask

    task automatic store_bytes(logic [63:0] addr, logic [2:0] size, logic [63:0] data);
        logic [63:0] byte_addr;
        for (int b = 0; b < (1 << size[1:0]); b++) begin
            byte_addr = addr + 64'(b);
            if (byte_addr >= DATA_BASE && byte_addr < DATA_BASE + 64'd512) begin
                dmem[(byte_addr - DATA_BASE) >> 3][8*byte_addr[2:0] +: 8] = data[8*b +: 8];
            end
        end
    endtask

    function automatic logic [63:0] load_word(logic [63:0] addr);
        if (addr < DATA_BASE || addr >= DATA_BASE + 64'd512) begin
            return '0;  // unmapped reads as zero
        end
        return dmem[(addr - DATA_BASE) >> 3] >> (8 * addr[2:0]);  // right aligned
    endfunction

    // instruction memory read straight from the image
    always_comb begin
        word_idx = (pc - `RESET_PC) >> 2;
        if (pc >= `RESET_PC && word_idx < pc_t'(prog_words)) begin
            instruction = stim[word_idx][31:0];
        end else begin
            instruction = 32'h0000_0013;  // nop outside the image
        end
    end

    always @(posedge clk) begin : bus_responder
        logic [63:0] addr_q;
        logic [2:0]  size_q;
        logic        wr;
        int          delay;
        if (bus_read_enable || bus_write_enable) begin
            addr_q = 64'(bus_address);
            size_q = bus_ls_type;
            wr     = bus_write_enable;
            delay  = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
            if (wr) begin
                check_store(addr_q, size_q, bus_write_data);
                store_bytes(addr_q, size_q, bus_write_data);
            end
            repeat (delay - 1) @(posedge clk);
            #2;
            if (wr) begin
                bus_write_done = 1'b1;
            end else begin
                bus_read_done = 1'b1;
                bus_read_data = load_word(addr_q);
            end
            @(posedge clk);
            #2;
            bus_write_done = 1'b0;
            bus_read_done  = 1'b0;
        end
    end

    always @(posedge clk) begin  // timeout and ack count
        if (interrupt_ack) ack_count <= ack_count + 1;
        if (reset) begin
            cycle <= cycle + 1;
            if (cycle >= timeout_cycles) begin
                report_failure($sformatf("timeout, no end marker store after %0d cycles", cycle));
            end
        end
    end

    initial begin
        seed           = 32'h847318ea;
        clk            = 1'b0;
        reset          = 1'b0;
        irq            = 1'b0;
        bus_read_done  = 1'b0;
        bus_write_done = 1'b0;
        bus_read_data  = '0;
        for (int i = 0; i < STIM_DEPTH; i++) stim[i] = '0;
        $readmemh("dv/riscv64_core_stimulus.hex", stim);
        for (int i = 0; i < 64; i++) dmem[i] = stim[DATA_IDX + i];
        irq_cycle      = int'(stim[INFO_IDX]);
        end_addr       = stim[INFO_IDX + 1];
        prog_words     = int'(stim[INFO_IDX + 2]);
        rec_count      = int'(stim[INFO_IDX + 3]);
        timeout_cycles = 40 * prog_words + 400;
        repeat (10) @(posedge clk);
        #2 reset = 1'b1;
        repeat (irq_cycle) @(posedge clk);
        #2 irq = 1'b1;  // program waits in its spin loop by now
        do @(posedge clk); while (!interrupt_ack);
        #2 irq = 1'b0;
        wait (end_seen);
        finish_run();
    end

endmodule

//--- hdl/core_ifs.sv
// decode to execute, everything one instruction needs
interface decoded_if import riscv64_core_pkg::*; ();
    logic        valid;      // ir holds a live instruction
    pc_t         ir_pc;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    xlen_t       rs1_val;
    xlen_t       rs2_val;
    xlen_t       imm;        // already picked by format
    logic [11:0] csr_addr;
    logic        mret;

    modport producer (output valid, ir_pc, opcode, funct3, funct7, rd,
                      rs1_val, rs2_val, imm, csr_addr, mret);
    modport consumer (input  valid, ir_pc, opcode, funct3, funct7, rd,
                      rs1_val, rs2_val, imm, csr_addr, mret);
endinterface

// execute to lsu, single outstanding transfer
interface mem_req_if import riscv64_core_pkg::*; ();
    logic     req;    // one cycle pulse
    logic     write;
    ls_size_e size;
    xlen_t    addr;
    xlen_t    wdata;
    logic     done;   // one cycle pulse, rdata valid with it
    xlen_t    rdata;  // already extended

    modport master (output req, write, size, addr, wdata, input done, rdata);
    modport slave  (input req, write, size, addr, wdata, output done, rdata);
endinterface

//--- hdl/csr_trap_unit.sv
`include "riscv64_core_settings.svh"

module csr_trap_unit import riscv64_core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        irq_i,
    input  logic        ir_valid_i,
    input  pc_t         ir_pc_i,
    input  logic        lsu_busy_i,
    input  logic        csr_we_i,
    input  logic [11:0] csr_addr_i,
    input  xlen_t       csr_wdata_i,
    input  logic        mret_i,
    output xlen_t       csr_rdata_o,
    output logic        irq_take_o,
    output pc_t         trap_target_o,
    output logic        interrupt_ack_o
);

    localparam int MIE  = 3;  // mstatus bits
    localparam int MPIE = 7;

    xlen_t mstatus, mtvec, mscratch, mepc, mcause;

    // squash the live instruction, never a memory op in flight
    assign irq_take_o    = irq_i && mstatus[MIE] && ir_valid_i && !lsu_busy_i;
    assign trap_target_o = irq_take_o ? pc_t'(mtvec) : pc_t'(mepc);

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS:  csr_rdata_o = mstatus;
            CSR_MTVEC:    csr_rdata_o = mtvec;
            CSR_MSCRATCH: csr_rdata_o = mscratch;
            CSR_MEPC:     csr_rdata_o = mepc;
            CSR_MCAUSE:   csr_rdata_o = mcause;
            default:      csr_rdata_o = '0;  // unknown csr
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus         <= xlen_t'(1) << MIE;  // interrupts on out of reset
            mtvec           <= '0;
            mscratch        <= '0;
            mepc            <= '0;
            mcause          <= '0;
            interrupt_ack_o <= 1'b0;
        end else begin
            interrupt_ack_o <= irq_take_o;
            if (irq_take_o) begin
                mepc          <= xlen_t'(ir_pc_i);  // squashed instruction reruns
                mcause        <= `MCAUSE_EXT_IRQ;
                mstatus[MPIE] <= mstatus[MIE];
                mstatus[MIE]  <= 1'b0;
            end else if (mret_i) begin
                mstatus[MIE]  <= mstatus[MPIE];
                mstatus[MPIE] <= 1'b1;
            end else if (csr_we_i) begin
                case (csr_addr_i)
                    CSR_MSTATUS:  mstatus  <= csr_wdata_i;
                    CSR_MTVEC:    mtvec    <= csr_wdata_i;
                    CSR_MSCRATCH: mscratch <= csr_wdata_i;
                    CSR_MEPC:     mepc     <= csr_wdata_i;
                    CSR_MCAUSE:   mcause   <= csr_wdata_i;
                    default:      mscratch <= mscratch;  // write dropped
                endcase
            end
        end
    end

endmodule

//--- hdl/decode_stage.sv
module decode_stage import riscv64_core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] ir_i,
    input  pc_t         ir_pc_i,
    input  logic        ir_valid_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_rd_i,
    input  xlen_t       wb_data_i,
    decoded_if.producer dec
);

    opcode_e opcode;
    xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t   rs1_val, rs2_val;

    assign opcode = opcode_e'(ir_i[6:0]);

    // immediate formats, all sign extended from ir[31]
    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    assign imm_j = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: dec.imm = imm_u;
            OP_JAL:           dec.imm = imm_j;
            OP_BRANCH:        dec.imm = imm_b;
            OP_STORE:         dec.imm = imm_s;
            default:          dec.imm = imm_i;  // loads, jalr, alu imm, csr
        endcase
    end

    reg_file u_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr_i (ir_i[19:15]),
        .rs2_addr_i (ir_i[24:20]),
        .rs1_data_o (rs1_val),
        .rs2_data_o (rs2_val),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i)
    );

    assign dec.valid    = ir_valid_i;
    assign dec.ir_pc    = ir_pc_i;
    assign dec.opcode   = opcode;
    assign dec.funct3   = ir_i[14:12];
    assign dec.funct7   = ir_i[31:25];
    assign dec.rd       = ir_i[11:7];
    assign dec.rs1_val  = rs1_val;
    assign dec.rs2_val  = rs2_val;
    assign dec.csr_addr = ir_i[31:20];
    assign dec.mret     = ir_i == 32'h3020_0073;  // the one exact encoding

endmodule

//--- hdl/execute_stage.sv
module execute_stage import riscv64_core_pkg::*; (
    decoded_if.consumer dec,
    mem_req_if.master   mem,
    input  logic        irq_take_i,
    input  pc_t         trap_target_i,  // mtvec on interrupt, mepc otherwise
    input  xlen_t       csr_rdata_i,
    output logic        csr_we_o,
    output logic [11:0] csr_addr_o,
    output xlen_t       csr_wdata_o,
    output logic        mret_o,
    output logic        redirect_o,
    output pc_t         target_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output xlen_t       wb_data_o
);

    logic        live;      // valid and not squashed by an interrupt
    logic        is_reg;    // register-register forms
    logic        sub_sra;   // funct7 bit 5
    logic        is_csrrw;
    logic        taken;
    logic        writes_rd;
    logic [5:0]  shamt;
    xlen_t       op_b;
    xlen_t       sra64;
    logic [31:0] sra32;
    xlen_t       alu_res;
    logic [31:0] word_res;
    xlen_t       rd_val;

    assign live     = dec.valid && !irq_take_i;
    assign is_reg   = dec.opcode inside {OP_REG, OP_REG_32};
    assign sub_sra  = dec.funct7[5];
    assign is_csrrw = dec.opcode == OP_SYSTEM && dec.funct3 == 3'b001;
    assign op_b     = is_reg ? dec.rs2_val : dec.imm;
    assign shamt    = op_b[5:0];  // word forms use only the low five
    assign sra64    = $signed(dec.rs1_val) >>> shamt;
    assign sra32    = $signed(dec.rs1_val[31:0]) >>> shamt[4:0];

    always_comb begin  // 64-bit alu
        case (dec.funct3)
            3'b000:  alu_res = (is_reg && sub_sra) ? dec.rs1_val - op_b : dec.rs1_val + op_b;
            3'b001:  alu_res = dec.rs1_val << shamt;
            3'b010:  alu_res = xlen_t'($signed(dec.rs1_val) < $signed(op_b));
            3'b011:  alu_res = xlen_t'(dec.rs1_val < op_b);
            3'b100:  alu_res = dec.rs1_val ^ op_b;
            3'b101:  alu_res = sub_sra ? sra64 : dec.rs1_val >> shamt;
            3'b110:  alu_res = dec.rs1_val | op_b;
            default: alu_res = dec.rs1_val & op_b;
        endcase
    end

    always_comb begin  // word forms, sign extended on writeback
        case (dec.funct3)
            3'b000: begin
                word_res = (is_reg && sub_sra) ? dec.rs1_val[31:0] - op_b[31:0]
                                               : dec.rs1_val[31:0] + op_b[31:0];
            end
            3'b001:  word_res = dec.rs1_val[31:0] << shamt[4:0];
            3'b101:  word_res = sub_sra ? sra32 : dec.rs1_val[31:0] >> shamt[4:0];
            default: word_res = '0;
        endcase
    end

    always_comb begin  // branch compare
        case (dec.funct3)
            3'b000:  taken = dec.rs1_val == dec.rs2_val;
            3'b001:  taken = dec.rs1_val != dec.rs2_val;
            3'b100:  taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
            3'b101:  taken = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
            3'b110:  taken = dec.rs1_val < dec.rs2_val;
            3'b111:  taken = dec.rs1_val >= dec.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin  // writeback source
        writes_rd = 1'b1;
        case (dec.opcode)
            OP_LUI:               rd_val = dec.imm;
            OP_AUIPC:             rd_val = xlen_t'(dec.ir_pc) + dec.imm;
            OP_JAL, OP_JALR:      rd_val = xlen_t'(dec.ir_pc + pc_t'(4));  // link
            OP_IMM, OP_REG:       rd_val = alu_res;
            OP_IMM_32, OP_REG_32: rd_val = {{32{word_res[31]}}, word_res};
            OP_SYSTEM: begin
                rd_val    = csr_rdata_i;  // old csr value
                writes_rd = is_csrrw;
            end
            default: begin
                rd_val    = mem.rdata;  // loads land on done below
                writes_rd = 1'b0;
            end
        endcase
    end

    // ir is still held on the load during the done cycle
    assign wb_we_o   = (live && writes_rd) || (mem.done && dec.opcode == OP_LOAD);
    assign wb_rd_o   = dec.rd;
    assign wb_data_o = rd_val;

    always_comb begin  // redirect and target
        redirect_o = irq_take_i;
        target_o   = trap_target_i;
        if (live) begin
            case (dec.opcode)
                OP_JAL: begin
                    redirect_o = 1'b1;
                    target_o   = dec.ir_pc + pc_t'(dec.imm);
                end
                OP_JALR: begin
                    redirect_o = 1'b1;
                    target_o   = pc_t'(dec.rs1_val + dec.imm) & ~pc_t'(1);
                end
                OP_BRANCH: begin
                    redirect_o = taken;
                    target_o   = dec.ir_pc + pc_t'(dec.imm);
                end
                OP_SYSTEM: redirect_o = dec.mret;  // back to mepc
                default:   redirect_o = 1'b0;
            endcase
        end
    end

    // not gated by irq_take, the csr unit holds interrupts off while the lsu is busy
    assign mem.req   = dec.valid && dec.opcode inside {OP_LOAD, OP_STORE};
    assign mem.write = dec.opcode == OP_STORE;
    assign mem.size  = ls_size_e'(dec.funct3);
    assign mem.addr  = dec.rs1_val + dec.imm;
    assign mem.wdata = dec.rs2_val;

    assign csr_we_o    = live && is_csrrw;
    assign csr_addr_o  = dec.csr_addr;
    assign csr_wdata_o = dec.rs1_val;
    assign mret_o      = live && dec.mret;

endmodule

//--- hdl/fetch_stage.sv
`include "riscv64_core_settings.svh"

module fetch_stage import riscv64_core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction_i,
    input  logic        stall_i,      // lsu transfer in flight
    input  logic        redirect_i,
    input  pc_t         target_i,
    output pc_t         pc_o,
    output logic [31:0] ir_o,
    output pc_t         ir_pc_o,
    output logic        ir_valid_o
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o       <= `RESET_PC;
            ir_valid_o <= 1'b0;
        end else if (stall_i) begin
            ir_valid_o <= 1'b0;  // held instruction already handed to the lsu
        end else begin
            pc_o       <= redirect_i ? target_i : pc_o + pc_t'(4);
            ir_valid_o <= !redirect_i;  // wrong path word turns into a bubble
        end
    end

    // instruction register, frozen while stalled
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ir_o    <= instruction_i;
            ir_pc_o <= pc_o;
        end
    end

endmodule

//--- hdl/load_store_unit.sv
`include "riscv64_core_settings.svh"

module load_store_unit import riscv64_core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    mem_req_if.slave               mem,
    output logic                   busy_o,
    output logic [`BUS_ADDR_W-1:0] bus_address_o,
    output xlen_t                  bus_write_data_o,
    output logic                   bus_write_enable_o,
    output logic                   bus_read_enable_o,
    output logic [2:0]             bus_ls_type_o,
    input  logic                   bus_read_done_i,
    input  logic                   bus_write_done_i,
    input  xlen_t                  bus_read_data_i
);

    logic     pending;  // transfer outstanding on the bus
    logic     accept;
    ls_size_e size_q;
    xlen_t    raw;

    assign accept        = mem.req && !pending;
    assign mem.done      = pending && (bus_read_done_i || bus_write_done_i);
    assign busy_o        = mem.req || (pending && !mem.done);  // fetch moves on at done
    assign bus_ls_type_o = size_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending            <= 1'b0;
            bus_read_enable_o  <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            bus_read_enable_o  <= accept && !mem.write;  // one cycle only
            bus_write_enable_o <= accept && mem.write;
            if (accept) begin
                pending <= 1'b1;
            end else if (mem.done) begin
                pending <= 1'b0;
            end
        end
    end

    // address, data and type stay put until done
    always_ff @(posedge clk) begin
        if (accept) begin
            bus_address_o    <= mem.addr[`BUS_ADDR_W-1:0];
            bus_write_data_o <= mem.wdata;
            size_q           <= mem.size;
        end
    end

    assign raw = bus_read_data_i;

    always_comb begin  // load extension by stored size
        case (size_q)
            LS_B:    mem.rdata = {{56{raw[7]}}, raw[7:0]};
            LS_H:    mem.rdata = {{48{raw[15]}}, raw[15:0]};
            LS_W:    mem.rdata = {{32{raw[31]}}, raw[31:0]};
            LS_BU:   mem.rdata = {56'b0, raw[7:0]};
            LS_HU:   mem.rdata = {48'b0, raw[15:0]};
            LS_WU:   mem.rdata = {32'b0, raw[31:0]};
            default: mem.rdata = raw;  // ld
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`include "riscv64_core_settings.svh"

module reg_file import riscv64_core_pkg::*; #(
    parameter int AW = $clog2(`NUM_REGS)
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [AW-1:0] rs1_addr_i,
    input  logic [AW-1:0] rs2_addr_i,
    output xlen_t         rs1_data_o,
    output xlen_t         rs2_data_o,
    input  logic          we_i,
    input  logic [AW-1:0] rd_addr_i,
    input  xlen_t         rd_data_i
);

    xlen_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;  // x0 stays zero
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];  // async reads
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

//--- hdl/riscv64_core.sv
`include "riscv64_core_settings.svh"

module riscv64_core import riscv64_core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            instruction_i,
    output pc_t                    pc_o,
    input  logic                   irq_i,
    output logic                   interrupt_ack_o,
    output logic [`BUS_ADDR_W-1:0] bus_address_o,
    output xlen_t                  bus_write_data_o,
    output logic                   bus_write_enable_o,
    output logic                   bus_read_enable_o,
    output logic [2:0]             bus_ls_type_o,
    input  logic                   bus_read_done_i,
    input  logic                   bus_write_done_i,
    input  xlen_t                  bus_read_data_i
);

    logic [31:0] ir;
    pc_t         ir_pc, target, trap_target;
    logic        ir_valid, redirect, lsu_busy, irq_take;
    logic        csr_we, mret, wb_we;
    logic [11:0] csr_addr;
    logic [4:0]  wb_rd;
    xlen_t       csr_wdata, csr_rdata, wb_data;

    decoded_if dec_bus ();
    mem_req_if mem_bus ();

    fetch_stage u_fetch (
        .clk (clk), .reset (reset), .instruction_i (instruction_i),
        .stall_i (lsu_busy), .redirect_i (redirect), .target_i (target),
        .pc_o (pc_o), .ir_o (ir), .ir_pc_o (ir_pc), .ir_valid_o (ir_valid)
    );

    decode_stage u_decode (
        .clk (clk), .reset (reset), .ir_i (ir), .ir_pc_i (ir_pc), .ir_valid_i (ir_valid),
        .wb_we_i (wb_we), .wb_rd_i (wb_rd), .wb_data_i (wb_data), .dec (dec_bus)
    );

    execute_stage u_execute (
        .dec (dec_bus), .mem (mem_bus), .irq_take_i (irq_take),
        .trap_target_i (trap_target), .csr_rdata_i (csr_rdata), .csr_we_o (csr_we),
        .csr_addr_o (csr_addr), .csr_wdata_o (csr_wdata), .mret_o (mret),
        .redirect_o (redirect), .target_o (target),
        .wb_we_o (wb_we), .wb_rd_o (wb_rd), .wb_data_o (wb_data)
    );

    load_store_unit u_lsu (
        .clk (clk), .reset (reset), .mem (mem_bus), .busy_o (lsu_busy),
        .bus_address_o (bus_address_o), .bus_write_data_o (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o), .bus_read_enable_o (bus_read_enable_o),
        .bus_ls_type_o (bus_ls_type_o), .bus_read_done_i (bus_read_done_i),
        .bus_write_done_i (bus_write_done_i), .bus_read_data_i (bus_read_data_i)
    );

    csr_trap_unit u_csr (
        .clk (clk), .reset (reset), .irq_i (irq_i), .ir_valid_i (ir_valid),
        .ir_pc_i (ir_pc), .lsu_busy_i (lsu_busy), .csr_we_i (csr_we),
        .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata), .mret_i (mret),
        .csr_rdata_o (csr_rdata), .irq_take_o (irq_take),
        .trap_target_o (trap_target), .interrupt_ack_o (interrupt_ack_o)
    );

endmodule

//--- hdl/riscv64_core_pkg.sv
`include "riscv64_core_settings.svh"

package riscv64_core_pkg;

    typedef logic [`XLEN-1:0] xlen_t;  // one integer register value
    typedef logic [`PC_W-1:0] pc_t;    // one fetch address

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_IMM_32 = 7'b0011011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_REG_32 = 7'b0111011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // load/store funct3, bit 2 set means zero extension
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_size_e;

    // machine csrs that are implemented
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_e;

endpackage

//--- include/riscv64_core_settings.svh
`ifndef RISCV64_CORE_SETTINGS_SVH
`define RISCV64_CORE_SETTINGS_SVH

// integer register width
`define XLEN 64

`define PC_W 40         // fetch address width
`define BUS_ADDR_W 39   // sv39 sized data bus address

// first fetch after reset, base of ram
`define RESET_PC 40'h00_8000_0000

// interrupt flag in the top bit, code 11 for machine external
`define MCAUSE_EXT_IRQ 64'h8000_0000_0000_000b

`define NUM_REGS 32     // x0 to x31

`endif

//--- riscv64_core.f
+incdir+include
hdl/riscv64_core_pkg.sv
hdl/core_ifs.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/load_store_unit.sv
hdl/csr_trap_unit.sv
hdl/riscv64_core.sv
dv/riscv64_core_tb.sv
